// File: hw/memory_unit.sv
// Memory-mapped I/O unit top level: decode, execute and result
`timescale 1ns/1ns

module memory_unit
(
    input  logic                   clk,
    input  logic                   reset,
    input  mu_pkg::mu_bus_req_t    i_bus,
    output mu_pkg::mu_word_t       o_bus_q,
    output logic                   o_bus_done,
    output mu_pkg::mu_vram32_req_t o_vram32,
    input  mu_pkg::mu_word_t       i_vram32_q,
    output mu_pkg::mu_vram8_req_t  o_vram8,
    input  logic [7:0]             i_vram8_q,
    output logic                   o_spi_clk,
    output logic                   o_spi_mosi,
    output logic                   o_spi_cs,
    input  logic                   i_spi_miso,
    input  logic                   i_spi_nint,
    input  logic [3:0]             i_gpi,
    output logic [3:0]             o_gpo
);

    import mu_pkg::*;

    mu_access_t access;
    logic       complete;
    logic [7:0] spi_rx;

    mu_decode u_decode
    (
        .i_bus    (i_bus),
        .o_access (access)
    );

    mu_execute u_execute
    (
        .clk        (clk),
        .reset      (reset),
        .i_access   (access),
        .o_vram32   (o_vram32),
        .o_vram8    (o_vram8),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso),
        .o_spi_cs   (o_spi_cs),
        .o_gpo      (o_gpo),
        .o_spi_rx   (spi_rx),
        .o_complete (complete)
    );

    // Register values read back through the pins they drive
    mu_result u_result
    (
        .clk        (clk),
        .reset      (reset),
        .i_access   (access),
        .i_complete (complete),
        .i_vram32_q (i_vram32_q),
        .i_vram8_q  (i_vram8_q),
        .i_spi_rx   (spi_rx),
        .i_spi_cs   (o_spi_cs),
        .i_spi_nint (i_spi_nint),
        .i_gpi      (i_gpi),
        .i_gpo      (o_gpo),
        .o_bus_q    (o_bus_q),
        .o_bus_done (o_bus_done)
    );

endmodule

// File: hw/mu_consts.svh
// Bus widths, window bases and sizes, register addresses and SPI timing
`ifndef MU_CONSTS_SVH
`define MU_CONSTS_SVH

// ----------------------------------------
// Bus and RAM port widths
// ----------------------------------------
`define MU_ADDR_W           27
`define MU_DATA_W           32
`define MU_VRAM_ADDR_W      14

// ----------------------------------------
// Video RAM windows
// ----------------------------------------
`define MU_VRAM32_BASE      27'hC00000
`define MU_VRAM32_SIZE      27'd1056
`define MU_VRAM8_BASE       27'hC00420
`define MU_VRAM8_SIZE       27'd8194

// ----------------------------------------
// I/O registers
// ----------------------------------------
`define MU_SPI_DATA_ADDR    27'hC0272B
`define MU_SPI_CS_ADDR      27'hC0272C
`define MU_SPI_NINT_ADDR    27'hC0272D
`define MU_GPIO_ADDR        27'hC02737

// System clocks per half SPI bit
`define MU_SPI_HALF_BIT     2

`endif

// File: hw/mu_decode.sv
// Address decoder: target classification and window offset
`timescale 1ns/1ns

module mu_decode
(
    input  mu_pkg::mu_bus_req_t i_bus,
    output mu_pkg::mu_access_t  o_access
);

    import mu_pkg::*;

    `include "mu_consts.svh"

    // First address past each window
    localparam mu_addr_t vram32_end = `MU_VRAM32_BASE + `MU_VRAM32_SIZE;
    localparam mu_addr_t vram8_end  = `MU_VRAM8_BASE + `MU_VRAM8_SIZE;

    mu_addr_t off32;
    mu_addr_t off8;
    logic     in_vram32;
    logic     in_vram8;

    // ----------------------------------------
    // Window ranges
    // ----------------------------------------
    assign off32 = i_bus.addr - `MU_VRAM32_BASE;
    assign off8  = i_bus.addr - `MU_VRAM8_BASE;

    assign in_vram32 = (i_bus.addr >= `MU_VRAM32_BASE) && (i_bus.addr < vram32_end);
    assign in_vram8  = (i_bus.addr >= `MU_VRAM8_BASE) && (i_bus.addr < vram8_end);

    // ----------------------------------------
    // Target select
    // ----------------------------------------
    always_comb
    begin
        o_access.start  = i_bus.start;
        o_access.we     = i_bus.we;
        o_access.wdata  = i_bus.data;
        o_access.offset = '0;
        o_access.target = tgt_unmapped;

        if (in_vram32)
        begin
            o_access.target = tgt_vram32;
            o_access.offset = off32[`MU_VRAM_ADDR_W-1:0];
        end
        else if (in_vram8)
        begin
            o_access.target = tgt_vram8;
            o_access.offset = off8[`MU_VRAM_ADDR_W-1:0];
        end
        else if (i_bus.addr == `MU_SPI_DATA_ADDR)
        begin
            o_access.target = tgt_spi_data;
        end
        else if (i_bus.addr == `MU_SPI_CS_ADDR)
        begin
            o_access.target = tgt_spi_cs;
        end
        else if (i_bus.addr == `MU_SPI_NINT_ADDR)
        begin
            o_access.target = tgt_spi_nint;
        end
        else if (i_bus.addr == `MU_GPIO_ADDR)
        begin
            o_access.target = tgt_gpio;
        end
    end

endmodule

// File: hw/mu_execute.sv
// Access sequencer with SPI chip-select and GPO registers and RAM port drive
`timescale 1ns/1ns

module mu_execute
(
    input  logic                   clk,
    input  logic                   reset,
    input  mu_pkg::mu_access_t     i_access,
    output mu_pkg::mu_vram32_req_t o_vram32,
    output mu_pkg::mu_vram8_req_t  o_vram8,
    output logic                   o_spi_clk,
    output logic                   o_spi_mosi,
    input  logic                   i_spi_miso,
    output logic                   o_spi_cs,
    output logic [3:0]             o_gpo,
    output logic [7:0]             o_spi_rx,
    output logic                   o_complete
);

    import mu_pkg::*;

    `include "mu_consts.svh"

    logic served;
    logic pending;
    logic is_vram;
    logic is_xfer;
    logic vram_write;
    logic accept;
    logic spi_start;
    logic spi_busy;
    logic spi_done;

    // ----------------------------------------
    // Access classes
    // ----------------------------------------
    assign is_vram    = (i_access.target == tgt_vram32) || (i_access.target == tgt_vram8);
    assign is_xfer    = (i_access.target == tgt_spi_data) && i_access.we;
    assign vram_write = is_vram && i_access.we;

    // New access, held off while the shift engine is still running
    assign accept    = i_access.start && !served && !pending && !(is_xfer && spi_busy);
    assign spi_start = accept && is_xfer;

    // VRAM writes finish at once, everything else one cycle later
    // except SPI transfers, which finish with the shift engine
    assign o_complete = (accept && vram_write)
                      || (pending && !is_xfer)
                      || (pending && is_xfer && spi_done);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            served  <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            if (!i_access.start)
                served <= 1'b0;
            else if (o_complete)
                served <= 1'b1;

            if (o_complete)
                pending <= 1'b0;
            else if (accept)
                pending <= 1'b1;
        end
    end

    // ----------------------------------------
    // Registers written on completion
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_spi_cs <= 1'b1;
            o_gpo    <= 4'd0;
        end
        else if (o_complete && i_access.we)
        begin
            if (i_access.target == tgt_spi_cs)
                o_spi_cs <= i_access.wdata.ctrl.flag;
            if (i_access.target == tgt_gpio)
                o_gpo <= i_access.wdata.ctrl.gpo;
        end
    end

    // ----------------------------------------
    // RAM ports
    // ----------------------------------------
    assign o_vram32.addr = i_access.offset;
    assign o_vram32.data = i_access.wdata;
    assign o_vram32.we   = i_access.start && i_access.we && !served
                         && (i_access.target == tgt_vram32);

    assign o_vram8.addr = i_access.offset;
    assign o_vram8.data = i_access.wdata.bytes.data;
    assign o_vram8.we   = i_access.start && i_access.we && !served
                        && (i_access.target == tgt_vram8);

    mu_spi_master
    #(
        .CLKS_PER_HALF_BIT (`MU_SPI_HALF_BIT)
    )
    u_spi
    (
        .clk        (clk),
        .reset      (reset),
        .i_start    (spi_start),
        .i_byte     (i_access.wdata.bytes.data),
        .o_busy     (spi_busy),
        .o_done     (spi_done),
        .o_byte     (o_spi_rx),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso)
    );

endmodule

// File: hw/mu_pkg.sv
// Bus, access, RAM request and write-data types of the memory unit
package mu_pkg;

    `include "mu_consts.svh"

    typedef logic [`MU_DATA_W-1:0] mu_word_t;
    typedef logic [`MU_ADDR_W-1:0] mu_addr_t;

    // Request from the bus master
    typedef struct packed {
        logic     start;
        logic     we;
        mu_addr_t addr;
        mu_word_t data;
    } mu_bus_req_t;

    // Written word seen as a data byte
    typedef struct packed {
        logic [23:0] unused;
        logic [7:0]  data;
    } mu_wbyte_t;

    // Written word seen as control fields
    typedef struct packed {
        logic [23:0] unused;
        logic [3:0]  gpo;
        logic [2:0]  unused_lo;
        logic        flag;
    } mu_wctrl_t;

    typedef union packed {
        mu_wbyte_t bytes;
        mu_wctrl_t ctrl;
    } mu_wdata_u;

    typedef enum logic [2:0] {
        tgt_unmapped,
        tgt_vram32,
        tgt_vram8,
        tgt_spi_data,
        tgt_spi_cs,
        tgt_spi_nint,
        tgt_gpio
    } mu_target_e;

    // Decoded access
    typedef struct packed {
        logic                      start;
        logic                      we;
        mu_target_e                target;
        logic [`MU_VRAM_ADDR_W-1:0] offset;
        mu_wdata_u                 wdata;
    } mu_access_t;

    typedef struct packed {
        logic [`MU_VRAM_ADDR_W-1:0] addr;
        mu_word_t                  data;
        logic                      we;
    } mu_vram32_req_t;

    typedef struct packed {
        logic [`MU_VRAM_ADDR_W-1:0] addr;
        logic [7:0]                data;
        logic                      we;
    } mu_vram8_req_t;

endpackage

// File: hw/mu_result.sv
// Read multiplexer, read-data latch and done register
`timescale 1ns/1ns

module mu_result
(
    input  logic               clk,
    input  logic               reset,
    input  mu_pkg::mu_access_t i_access,
    input  logic               i_complete,
    input  mu_pkg::mu_word_t   i_vram32_q,
    input  logic [7:0]         i_vram8_q,
    input  logic [7:0]         i_spi_rx,
    input  logic               i_spi_cs,
    input  logic               i_spi_nint,
    input  logic [3:0]         i_gpi,
    input  logic [3:0]         i_gpo,
    output mu_pkg::mu_word_t   o_bus_q,
    output logic               o_bus_done
);

    import mu_pkg::*;

    mu_word_t rd_word;

    // ----------------------------------------
    // Read select
    // ----------------------------------------
    always_comb
    begin
        case (i_access.target)
            tgt_vram32:
                rd_word = i_vram32_q;
            tgt_vram8:
                rd_word = {24'd0, i_vram8_q};
            tgt_spi_data:
                rd_word = {24'd0, i_spi_rx};
            tgt_spi_cs:
                rd_word = {31'd0, i_spi_cs};
            tgt_spi_nint:
                rd_word = {31'd0, i_spi_nint};
            tgt_gpio:
                // Outputs in the upper nibble, inputs below
                rd_word = {24'd0, i_gpo, i_gpi};
            default:
                rd_word = '0;
        endcase
    end

    // ----------------------------------------
    // Bus outputs
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_bus_q    <= '0;
            o_bus_done <= 1'b0;
        end
        else
        begin
            o_bus_done <= i_complete;

            // Write cycles leave the last read word in place
            if (i_complete && !i_access.we)
                o_bus_q <= rd_word;
        end
    end

endmodule

// File: hw/mu_spi_master.sv
// Byte-wide SPI mode-0 master, MSB first
`timescale 1ns/1ns

module mu_spi_master
#(
    parameter int CLKS_PER_HALF_BIT = 2
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_busy,
    output logic       o_done,
    output logic [7:0] o_byte,
    output logic       o_spi_clk,
    output logic       o_spi_mosi,
    input  logic       i_spi_miso
);

    localparam int CNT_W = $clog2(CLKS_PER_HALF_BIT + 1);
    localparam logic [CNT_W-1:0] cnt_last = CNT_W'(CLKS_PER_HALF_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    // Counts SPI clock edges, two per bit
    logic [3:0]       edge_cnt;
    logic [7:0]       tx_shift;
    logic [7:0]       rx_shift;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_busy     <= 1'b0;
            o_done     <= 1'b0;
            o_byte     <= 8'd0;
            o_spi_clk  <= 1'b0;
            o_spi_mosi <= 1'b0;
            clk_cnt    <= '0;
            edge_cnt   <= 4'd0;
        end
        else
        begin
            o_done <= 1'b0;

            if (!o_busy)
            begin
                // First bit goes out half a bit before the first rising edge
                if (i_start)
                begin
                    o_busy     <= 1'b1;
                    o_spi_mosi <= i_byte[7];
                    tx_shift   <= {i_byte[6:0], 1'b0};
                    clk_cnt    <= '0;
                    edge_cnt   <= 4'd0;
                end
            end
            else if (clk_cnt == cnt_last)
            begin
                clk_cnt   <= '0;
                o_spi_clk <= ~o_spi_clk;
                edge_cnt  <= edge_cnt + 4'd1;

                if (!o_spi_clk)
                begin
                    // Rising edge samples MISO
                    rx_shift <= {rx_shift[6:0], i_spi_miso};
                end
                else if (edge_cnt == 4'd15)
                begin
                    // Clock back at idle, byte complete
                    o_busy <= 1'b0;
                    o_done <= 1'b1;
                    o_byte <= rx_shift;
                end
                else
                begin
                    o_spi_mosi <= tx_shift[7];
                    tx_shift   <= {tx_shift[6:0], 1'b0};
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

// File: memory_unit.f
+incdir+hw
hw/mu_pkg.sv
hw/mu_decode.sv
hw/mu_spi_master.sv
hw/mu_execute.sv
hw/mu_result.sv
hw/memory_unit.sv
tb/memory_unit_chk.sv
tb/memory_unit_tb.sv

// File: tb/memory_unit_chk.sv
// Bound checker with concurrent bus, RAM port and chip-select assertions
`timescale 1ns/1ns

module memory_unit_chk
(
    input logic                   clk,
    input logic                   reset,
    input mu_pkg::mu_bus_req_t    i_bus,
    input logic                   i_bus_done,
    input mu_pkg::mu_vram32_req_t i_vram32,
    input mu_pkg::mu_vram8_req_t  i_vram8,
    input logic                   i_spi_cs
);

    import mu_pkg::*;

    `include "mu_consts.svh"

    // First address past each window
    localparam mu_addr_t vram32_end = `MU_VRAM32_BASE + `MU_VRAM32_SIZE;
    localparam mu_addr_t vram8_end  = `MU_VRAM8_BASE + `MU_VRAM8_SIZE;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    done_single: assert property (@(posedge clk) disable iff (reset)
        i_bus_done |=> !i_bus_done)
        else $error("o_bus_done high in two cycles in a row");

    // ----------------------------------------
    // RAM write enables
    // ----------------------------------------
    vram32_we: assert property (@(posedge clk) disable iff (reset)
        $rose(i_vram32.we) |-> (i_bus.start && i_bus.we
            && (i_bus.addr >= `MU_VRAM32_BASE) && (i_bus.addr < vram32_end)))
        else $error("VRAM32 write enable rose outside a VRAM32 write");

    vram8_we: assert property (@(posedge clk) disable iff (reset)
        $rose(i_vram8.we) |-> (i_bus.start && i_bus.we
            && (i_bus.addr >= `MU_VRAM8_BASE) && (i_bus.addr < vram8_end)))
        else $error("VRAM8 write enable rose outside a VRAM8 write");

    // Chip select moves only together with the done of a chip-select write
    cs_stable: assert property (@(posedge clk) disable iff (reset)
        $changed(i_spi_cs) |-> i_bus_done
            && $past(i_bus.start && i_bus.we && (i_bus.addr == `MU_SPI_CS_ADDR)))
        else $error("o_spi_cs changed outside a chip-select access");

endmodule

bind memory_unit memory_unit_chk u_chk
(
    .clk        (clk),
    .reset      (reset),
    .i_bus      (i_bus),
    .i_bus_done (o_bus_done),
    .i_vram32   (o_vram32),
    .i_vram8    (o_vram8),
    .i_spi_cs   (o_spi_cs)
);

// File: tb/memory_unit_tb.sv
// Testbench for the memory unit with clock, RAM models, SPI loopback, random tests and report
`timescale 1ns/1ns

module memory_unit_tb;

    import mu_pkg::*;

    `include "mu_consts.svh"

    localparam int n_ram      = 24;
    localparam int n_spi      = 6;
    localparam int n_gpio     = 8;
    localparam int n_unmap    = 8;
    localparam int n_accesses = 4 * n_ram + 5 * n_spi + 2 * n_gpio + 2 * n_unmap + 3;
    localparam int max_cycles = n_accesses * 80 + 100;

    logic           clk = 1'b0;
    logic           reset;
    mu_bus_req_t    bus;
    mu_word_t       bus_q;
    logic           bus_done;
    mu_vram32_req_t vram32;
    mu_word_t       vram32_q = '0;
    mu_vram8_req_t  vram8;
    logic [7:0]     vram8_q = 8'd0;
    logic           spi_clk;
    logic           spi_mosi;
    logic           spi_cs;
    logic           spi_nint;
    logic [3:0]     gpi;
    logic [3:0]     gpo;

    // RAM models and reference copies
    mu_word_t   ram32 [0:16383];
    logic [7:0] ram8  [0:16383];
    mu_word_t   exp32 [0:16383];
    logic [7:0] exp8  [0:16383];
    logic       exp_cs;
    logic [3:0] exp_gpo;
    logic [7:0] exp_spi;

    int cycles = 0;
    int test_checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int total_errors = 0;

    always #4 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    // MOSI looped back to MISO
    memory_unit dut
    (
        .clk        (clk),
        .reset      (reset),
        .i_bus      (bus),
        .o_bus_q    (bus_q),
        .o_bus_done (bus_done),
        .o_vram32   (vram32),
        .i_vram32_q (vram32_q),
        .o_vram8    (vram8),
        .i_vram8_q  (vram8_q),
        .o_spi_clk  (spi_clk),
        .o_spi_mosi (spi_mosi),
        .o_spi_cs   (spi_cs),
        .i_spi_miso (spi_mosi),
        .i_spi_nint (spi_nint),
        .i_gpi      (gpi),
        .o_gpo      (gpo)
    );

    // Synchronous RAMs, one cycle read latency
    always @(posedge clk)
    begin
        if (vram32.we)
            ram32[vram32.addr] <= vram32.data;
        if (vram8.we)
            ram8[vram8.addr] <= vram8.data;
        vram32_q <= ram32[vram32.addr];
        vram8_q  <= ram8[vram8.addr];
    end

    // ----------------------------------------
    // Fill patterns and compare tasks
    // ----------------------------------------
    function automatic mu_word_t fill_word(input int idx);
        logic [13:0] a;
        a = idx[13:0];
        return {2'b10, a, ~a, 2'b01};
    endfunction

    function automatic logic [7:0] fill_byte(input int idx);
        logic [13:0] a;
        a = idx[13:0];
        return a[7:0] ^ {2'b00, a[13:8]};
    endfunction

    task automatic check_word(input string name, input mu_word_t got, input mu_word_t exp);
        test_checks++;
        if (got !== exp)
        begin
            test_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_gpo(input string name, input logic [3:0] got, input logic [3:0] exp);
        test_checks++;
        if (got !== exp)
        begin
            test_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        test_checks++;
        if (got !== exp)
        begin
            test_errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-9s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // ----------------------------------------
    // Bus master
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // A latency of zero waits for done without a fixed count
    task automatic bus_access(input logic we, input mu_addr_t addr, input mu_word_t data,
                              input int lat, output mu_word_t q);
        bus.start = 1'b1;
        bus.we    = we;
        bus.addr  = addr;
        bus.data  = data;
        if (lat > 0)
        begin
            for (int n = 1; n <= lat; n++)
            begin
                next_cycle();
                check_bit("o_bus_done", bus_done, n == lat);
            end
        end
        else
        begin
            next_cycle();
            while (!bus_done)
                next_cycle();
        end
        q = bus_q;
        next_cycle();
        check_bit("o_bus_done", bus_done, 1'b0);
        bus.start = 1'b0;
        next_cycle();
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic ram_test(input logic wide);
        mu_addr_t    base;
        int unsigned size;
        logic [13:0] off;
        logic [13:0] hits [$];
        mu_word_t    data;
        mu_word_t    q;
        logic        we;
        base = wide ? `MU_VRAM32_BASE : `MU_VRAM8_BASE;
        size = wide ? `MU_VRAM32_SIZE : `MU_VRAM8_SIZE;
        for (int i = 0; i < 2 * n_ram; i++)
        begin
            we   = 1'($urandom % 2);
            data = $urandom;
            // Reads often revisit a written offset
            if (hits.size() > 0 && 1'($urandom % 2))
                off = hits[$urandom % hits.size()];
            else
                off = 14'($urandom % size);
            if (we)
            begin
                bus_access(1'b1, base + mu_addr_t'(off), data, 1, q);
                if (wide)
                    exp32[off] = data;
                else
                    exp8[off] = data[7:0];
                hits.push_back(off);
            end
            else
            begin
                bus_access(1'b0, base + mu_addr_t'(off), '0, 2, q);
                check_word("o_bus_q", q, wide ? exp32[off] : {24'd0, exp8[off]});
            end
        end
    endtask

    task automatic spi_test();
        mu_word_t data;
        mu_word_t q;
        for (int i = 0; i < n_spi; i++)
        begin
            data   = $urandom;
            exp_cs = data[0];
            bus_access(1'b1, `MU_SPI_CS_ADDR, data, 2, q);
            check_bit("o_spi_cs", spi_cs, exp_cs);
            check_gpo("o_gpo", gpo, exp_gpo);
            bus_access(1'b0, `MU_SPI_CS_ADDR, '0, 2, q);
            check_word("o_bus_q", q, {31'd0, exp_cs});
            data    = $urandom;
            exp_spi = data[7:0];
            bus_access(1'b1, `MU_SPI_DATA_ADDR, data, 0, q);
            // SPI clock back at idle after the transfer
            check_bit("o_spi_clk", spi_clk, 1'b0);
            bus_access(1'b0, `MU_SPI_DATA_ADDR, '0, 2, q);
            check_word("o_bus_q", q, {24'd0, exp_spi});
            spi_nint = 1'($urandom % 2);
            bus_access(1'b0, `MU_SPI_NINT_ADDR, '0, 2, q);
            check_word("o_bus_q", q, {31'd0, spi_nint});
        end
    endtask

    task automatic gpio_test();
        mu_word_t data;
        mu_word_t q;
        for (int i = 0; i < n_gpio; i++)
        begin
            gpi     = 4'($urandom);
            data    = $urandom;
            exp_gpo = data[7:4];
            bus_access(1'b1, `MU_GPIO_ADDR, data, 2, q);
            check_gpo("o_gpo", gpo, exp_gpo);
            check_bit("o_spi_cs", spi_cs, exp_cs);
            bus_access(1'b0, `MU_GPIO_ADDR, '0, 2, q);
            check_word("o_bus_q", q, {24'd0, exp_gpo, gpi});
        end
    endtask

    task automatic unmapped_test();
        mu_addr_t addr;
        mu_word_t q;
        for (int i = 0; i < n_unmap; i++)
        begin
            // Below VRAM32 or in the gap between nint and GPIO
            if (i % 2 == 0)
                addr = mu_addr_t'($urandom % `MU_VRAM32_BASE);
            else
                addr = `MU_SPI_NINT_ADDR + 27'd1
                     + mu_addr_t'($urandom % (`MU_GPIO_ADDR - `MU_SPI_NINT_ADDR - 1));
            bus_access(1'b1, addr, $urandom, 2, q);
            check_bit("o_spi_cs", spi_cs, exp_cs);
            check_gpo("o_gpo", gpo, exp_gpo);
            bus_access(1'b0, addr, '0, 2, q);
            check_word("o_bus_q", q, '0);
        end
        // Offset zero is where a stray write would land
        bus_access(1'b0, `MU_VRAM32_BASE, '0, 2, q);
        check_word("o_bus_q", q, exp32[0]);
        bus_access(1'b0, `MU_VRAM8_BASE, '0, 2, q);
        check_word("o_bus_q", q, {24'd0, exp8[0]});
        bus_access(1'b0, `MU_SPI_DATA_ADDR, '0, 2, q);
        check_word("o_bus_q", q, {24'd0, exp_spi});
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    initial
    begin
        wait (cycles >= max_cycles);
        $display("Timeout: no result after %0d cycles, an access never completed", cycles);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        void'($urandom(53468));
        reset    = 1'b1;
        bus      = '0;
        spi_nint = 1'b1;
        gpi      = 4'd0;
        exp_cs   = 1'b1;
        exp_gpo  = 4'd0;
        exp_spi  = 8'd0;
        for (int i = 0; i < 16384; i++)
        begin
            ram32[i] = fill_word(i);
            exp32[i] = fill_word(i);
            ram8[i]  = fill_byte(i);
            exp8[i]  = fill_byte(i);
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        check_bit("o_bus_done", bus_done, 1'b0);
        check_bit("o_spi_cs", spi_cs, 1'b1);
        check_bit("o_spi_clk", spi_clk, 1'b0);
        check_gpo("o_gpo", gpo, 4'd0);
        check_bit("o_vram32.we", vram32.we, 1'b0);
        check_bit("o_vram8.we", vram8.we, 1'b0);
        check_word("o_bus_q", bus_q, '0);
        finish_test("reset");
        ram_test(1'b1);
        finish_test("vram32");
        ram_test(1'b0);
        finish_test("vram8");
        spi_test();
        finish_test("spi");
        gpio_test();
        finish_test("gpio");
        unmapped_test();
        finish_test("unmapped");

        $display("Checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
